// ==== common/isa_pkg.sv ====
// instruction encoding: word and field types, opcodes, function codes, instruction union.
package isa_pkg;

    typedef logic [31:0] word_t;           // data or address word.
    typedef logic [4:0]  register_index_t; // register number.
    typedef logic [5:0]  opcode_t;

    // opcodes of the supported instructions.
    localparam opcode_t op_r_type = 6'd0;
    localparam opcode_t op_addi   = 6'd8;
    localparam opcode_t op_load   = 6'd35;
    localparam opcode_t op_store  = 6'd43;

    // function codes, only meaningful with op_r_type.
    localparam logic [5:0] funct_add = 6'd32;
    localparam logic [5:0] funct_sub = 6'd34;
    localparam logic [5:0] funct_and = 6'd36;
    localparam logic [5:0] funct_or  = 6'd37;
    localparam logic [5:0] funct_nor = 6'd39;
    localparam logic [5:0] funct_slt = 6'd42;

    // register format.
    typedef struct packed {
        opcode_t         opcode;
        register_index_t rs;
        register_index_t rt;
        register_index_t rd;
        logic [4:0]      shift_amount;
        logic [5:0]      funct;
    } r_fields_t;

    // immediate format, used by addi, lw and sw.
    typedef struct packed {
        opcode_t         opcode;
        register_index_t rs;
        register_index_t rt;
        logic [15:0]     immediate;
    } i_fields_t;

    // one fetched word, seen either way.
    // opcode, rs and rt sit at the same bits in both views.
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instruction_u;

endpackage

// ==== common/pipeline_pkg.sv ====
// pipeline definitions: fetch constants, data memory depth, ALU operations, stage registers.
package pipeline_pkg;

    localparam isa_pkg::word_t reset_vector = 32'd100; // first fetch address.
    localparam isa_pkg::word_t pc_step      = 32'd4;
    localparam int             data_words   = 256;     // addressed by result bits 9 to 2.

    // ALU encodings, same values as the older control unit.
    typedef enum logic [3:0] {
        alu_and = 4'b0000,
        alu_or  = 4'b0001,
        alu_add = 4'b0010,
        alu_sub = 4'b0110,
        alu_slt = 4'b0111,
        alu_nor = 4'b1100
    } alu_op_t;

    // all zero is a bubble.
    typedef struct packed {
        logic    register_write;
        logic    memory_to_register; // write back the loaded word.
        logic    memory_write;
        logic    alu_immediate;      // second operand is the immediate.
        alu_op_t alu_op;
    } control_t;

    // decode/execute register.
    typedef struct packed {
        control_t                 control;
        isa_pkg::register_index_t destination;
        isa_pkg::word_t           rs_data;
        isa_pkg::word_t           rt_data;
        isa_pkg::word_t           immediate; // already sign-extended.
    } decode_execute_t;

    // execute/memory register.
    typedef struct packed {
        logic                     register_write;
        logic                     memory_to_register;
        logic                     memory_write;
        isa_pkg::register_index_t destination;
        isa_pkg::word_t           result;  // ALU result, also the memory address.
        isa_pkg::word_t           rt_data; // store data.
    } execute_memory_t;

    // memory/writeback register and register file write port.
    typedef struct packed {
        logic                     register_write;
        isa_pkg::register_index_t destination;
        isa_pkg::word_t           data;
    } writeback_t;

endpackage

// ==== fetch/fetch_stage.sv ====
// fetch_stage: program counter and fetch/decode instruction register.
`timescale 1ns/1ps

module fetch_stage (
    input  logic                  clock,
    input  logic                  reset,
    input  isa_pkg::word_t        instruction,
    output isa_pkg::word_t        pc,
    output isa_pkg::instruction_u fetched
);

    // no branches, so the pc only steps.
    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= pipeline_pkg::reset_vector;
        end else begin
            pc <= pc + pipeline_pkg::pc_step;
        end
    end

    // a zero word decodes as a bubble.
    always_ff @(posedge clock) begin
        if (reset) begin
            fetched <= '0;
        end else begin
            fetched <= instruction;
        end
    end

    // the outside memory is word addressed through pc.
    pc_aligned: assert property (@(posedge clock) disable iff (reset)
        pc[1:0] == 2'b00);

endmodule

// ==== decode/register_file.sv ====
// register_file: 32 words, two combinational read ports, one clocked write port.
`timescale 1ns/1ps

module register_file (
    input  logic                     clock,
    input  logic                     reset,
    input  isa_pkg::register_index_t rs_index,
    input  isa_pkg::register_index_t rt_index,
    input  pipeline_pkg::writeback_t write,
    output isa_pkg::word_t           rs_data,
    output isa_pkg::word_t           rt_data
);

    isa_pkg::word_t registers [32];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int index = 0; index < 32; index++) begin
                registers[index] <= '0;
            end
        end else if (write.register_write && (write.destination != '0)) begin
            registers[write.destination] <= write.data;
        end
    end

    // register 0 reads zero whatever is stored there.
    assign rs_data = (rs_index == '0) ? '0 : registers[rs_index];
    assign rt_data = (rt_index == '0) ? '0 : registers[rt_index];

endmodule

// ==== decode/decode_stage.sv ====
// decode_stage: control decode, destination select, sign extension, decode/execute register.
`timescale 1ns/1ps

module decode_stage (
    input  logic                          clock,
    input  logic                          reset,
    input  isa_pkg::instruction_u         fetched,
    input  pipeline_pkg::writeback_t      writeback,
    output pipeline_pkg::decode_execute_t decoded
);

    pipeline_pkg::control_t   control;
    isa_pkg::register_index_t destination;
    isa_pkg::word_t           immediate;
    isa_pkg::word_t           rs_data;
    isa_pkg::word_t           rt_data;

    register_file registers (
        .clock    (clock),
        .reset    (reset),
        .rs_index (fetched.i.rs),
        .rt_index (fetched.i.rt),
        .write    (writeback),
        .rs_data  (rs_data),
        .rt_data  (rt_data)
    );

    always_comb begin
        control = '0; // anything unknown stays a bubble.
        case (fetched.r.opcode)
            isa_pkg::op_r_type: begin
                control.register_write = 1'b1;
                case (fetched.r.funct)
                    isa_pkg::funct_add: control.alu_op = pipeline_pkg::alu_add;
                    isa_pkg::funct_sub: control.alu_op = pipeline_pkg::alu_sub;
                    isa_pkg::funct_and: control.alu_op = pipeline_pkg::alu_and;
                    isa_pkg::funct_or:  control.alu_op = pipeline_pkg::alu_or;
                    isa_pkg::funct_nor: control.alu_op = pipeline_pkg::alu_nor;
                    isa_pkg::funct_slt: control.alu_op = pipeline_pkg::alu_slt;
                    default:            control = '0;
                endcase
            end
            isa_pkg::op_addi: begin
                control.register_write = 1'b1;
                control.alu_immediate  = 1'b1;
                control.alu_op         = pipeline_pkg::alu_add;
            end
            isa_pkg::op_load: begin
                control.register_write     = 1'b1;
                control.memory_to_register = 1'b1;
                control.alu_immediate      = 1'b1;
                control.alu_op             = pipeline_pkg::alu_add; // base plus offset.
            end
            isa_pkg::op_store: begin
                control.memory_write  = 1'b1;
                control.alu_immediate = 1'b1;
                control.alu_op        = pipeline_pkg::alu_add;
            end
            default: control = '0;
        endcase
    end

    // rd for register format, rt for the rest.
    assign destination = (fetched.r.opcode == isa_pkg::op_r_type) ? fetched.r.rd : fetched.i.rt;
    assign immediate   = {{16{fetched.i.immediate[15]}}, fetched.i.immediate};

    always_ff @(posedge clock) begin
        if (reset) begin
            decoded <= '0;
        end else begin
            decoded.control     <= control;
            decoded.destination <= destination;
            decoded.rs_data     <= rs_data;
            decoded.rt_data     <= rt_data;
            decoded.immediate   <= immediate;
        end
    end

    // a store must never also claim a register write further down.
    write_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(decoded.control.register_write && decoded.control.memory_write));

endmodule

// ==== execute/execute_stage.sv ====
// execute_stage: second operand select, ALU and execute/memory register.
`timescale 1ns/1ps

module execute_stage (
    input  logic                          clock,
    input  logic                          reset,
    input  pipeline_pkg::decode_execute_t decoded,
    output pipeline_pkg::execute_memory_t executed
);

    isa_pkg::word_t second_operand;
    isa_pkg::word_t result;

    assign second_operand = decoded.control.alu_immediate ? decoded.immediate : decoded.rt_data;

    always_comb begin
        case (decoded.control.alu_op)
            pipeline_pkg::alu_and: result = decoded.rs_data & second_operand;
            pipeline_pkg::alu_or:  result = decoded.rs_data | second_operand;
            pipeline_pkg::alu_add: result = decoded.rs_data + second_operand;
            pipeline_pkg::alu_sub: result = decoded.rs_data - second_operand;
            pipeline_pkg::alu_nor: result = ~(decoded.rs_data | second_operand);
            pipeline_pkg::alu_slt: begin
                // signed compare.
                result = ($signed(decoded.rs_data) < $signed(second_operand)) ? 32'd1 : 32'd0;
            end
            default: result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            executed <= '0;
        end else begin
            executed.register_write     <= decoded.control.register_write;
            executed.memory_to_register <= decoded.control.memory_to_register;
            executed.memory_write       <= decoded.control.memory_write;
            executed.destination        <= decoded.destination;
            executed.result             <= result;
            executed.rt_data            <= decoded.rt_data; // store data.
        end
    end

endmodule

// ==== memory/memory_stage.sv ====
// memory_stage: data memory, writeback data select and memory/writeback register.
`timescale 1ns/1ps

module memory_stage (
    input  logic                          clock,
    input  logic                          reset,
    input  pipeline_pkg::execute_memory_t executed,
    output pipeline_pkg::writeback_t      writeback
);

    isa_pkg::word_t data_memory [pipeline_pkg::data_words];

    logic [$clog2(pipeline_pkg::data_words)-1:0] address;
    isa_pkg::word_t load_data;

    assign address   = executed.result[$clog2(pipeline_pkg::data_words)+1:2]; // word index.
    assign load_data = data_memory[address];

    // written on the edge that ends the memory cycle.
    always_ff @(posedge clock) begin
        if (executed.memory_write) begin
            data_memory[address] <= executed.rt_data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            writeback <= '0;
        end else begin
            writeback.register_write <= executed.register_write;
            writeback.destination    <= executed.destination;
            writeback.data           <= executed.memory_to_register ? load_data : executed.result;
        end
    end

    // base plus offset must land on a word.
    access_aligned: assert property (@(posedge clock) disable iff (reset)
        (executed.memory_write || executed.memory_to_register) |-> executed.result[1:0] == 2'b00);

endmodule

// ==== design/processor.sv ====
// processor: top level chaining the fetch, decode, execute and memory stages.
`timescale 1ns/1ps

module processor (
    input  logic                   clock,
    input  logic                   reset,
    input  isa_pkg::word_t         instruction, // served from pc in the same cycle.
    output isa_pkg::word_t         pc,
    output pipeline_pkg::writeback_t writeback
);

    isa_pkg::instruction_u         fetched;
    pipeline_pkg::decode_execute_t decoded;
    pipeline_pkg::execute_memory_t executed;

    fetch_stage fetch (
        .clock       (clock),
        .reset       (reset),
        .instruction (instruction),
        .pc          (pc),
        .fetched     (fetched)
    );

    // writeback loops back here for the register file write.
    decode_stage decode (
        .clock     (clock),
        .reset     (reset),
        .fetched   (fetched),
        .writeback (writeback),
        .decoded   (decoded)
    );

    execute_stage execute (
        .clock    (clock),
        .reset    (reset),
        .decoded  (decoded),
        .executed (executed)
    );

    memory_stage memory (
        .clock     (clock),
        .reset     (reset),
        .executed  (executed),
        .writeback (writeback)
    );

endmodule

// ==== bench/processor_tb.sv ====
// processor_tb: clock and reset, instruction memory from the testdata file, writeback checks.
`timescale 1ns/1ps

module processor_tb;

    localparam int max_entries = 64;
    localparam int columns     = 5; // instruction, write, destination, data, test.
    localparam int test_count  = 6;

    logic                     clock;
    logic                     reset;
    isa_pkg::word_t           instruction;
    isa_pkg::word_t           pc;
    pipeline_pkg::writeback_t writeback;

    logic [31:0] entries [columns*max_entries];
    int entry_count  = 0;
    int cycle_limit  = 0;
    int cycles       = 0;
    int check_count  = 0;
    int error_count  = 0;
    int current_test = 1;
    int test_errors [1:test_count];

    processor UUT (
        .clock       (clock),
        .reset       (reset),
        .instruction (instruction),
        .pc          (pc),
        .writeback   (writeback)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) cycles <= cycles + 1;

    function automatic string test_name(input int number);
        case (number)
            1:       return "reset and pc sequence";
            2:       return "addi chain";
            3:       return "register format alu";
            4:       return "register 0";
            5:       return "store and load";
            6:       return "bubbles";
            default: return "unknown";
        endcase
    endfunction

    // instruction memory, word index counted from the reset vector.
    function automatic isa_pkg::word_t program_word(input isa_pkg::word_t address);
        isa_pkg::word_t index;
        index = (address - pipeline_pkg::reset_vector) >> 2;
        if (index < entry_count) return entries[columns*index];
        return '0; // past the end of the program.
    endfunction

    task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                                 input string message);
        check_count++;
        if (actual !== expected) begin
            $display("mismatch at %0d ns: %s, got %h, expected %h",
                     $time, message, actual, expected);
            error_count++;
            test_errors[current_test]++;
        end
    endtask

    // destination and data only matter when the write flag is set.
    task automatic verify_writeback(input int entry);
        int base;
        base = columns * entry;
        compare_value(writeback.register_write, entries[base+1],
                      $sformatf("entry %0d write flag", entry));
        if (entries[base+1][0]) begin
            compare_value(writeback.destination, entries[base+2],
                          $sformatf("entry %0d destination", entry));
            compare_value(writeback.data, entries[base+3], $sformatf("entry %0d data", entry));
        end
    endtask

    task automatic report_test(input int number);
        $display("test %0d %s: %s, %0d errors", number, test_name(number),
                 (test_errors[number] == 0) ? "passed" : "failed", test_errors[number]);
    endtask

    initial begin
        int cycle;
        int entry;
        reset       = 1'b1;
        instruction = '0;
        $readmemh("bench/program_testdata.txt", entries);
        while (entry_count < max_entries && entries[columns*entry_count] !== 'x) begin
            entry_count++;
        end
        cycle_limit = 16 + entry_count + 4 + 20;
        if (entry_count == 0) begin
            $display("error: no program was read from bench/program_testdata.txt");
            error_count++;
        end

        repeat (16) begin
            @(posedge clock);
            #10;
            compare_value(pc, pipeline_pkg::reset_vector, "pc during reset");
            compare_value(writeback.register_write, 1'b0, "write flag during reset");
        end
        reset       = 1'b0;
        instruction = program_word(pc);

        // entry k leaves writeback four cycles after its fetch.
        for (cycle = 0; cycle < entry_count + 4; cycle++) begin
            entry = cycle - 4;
            if (entry >= 0) current_test = entries[columns*entry+4];
            compare_value(pc, pipeline_pkg::reset_vector + 4 * cycle, "pc");
            if (entry < 0) begin
                compare_value(writeback.register_write, 1'b0, "write flag while filling");
                if (cycle == 3) report_test(1);
            end else begin
                verify_writeback(entry);
                if (entry == entry_count - 1 || entries[columns*(entry+1)+4] != current_test) begin
                    report_test(current_test);
                end
            end
            @(posedge clock);
            #10;
            instruction = program_word(pc);
        end

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        wait (cycle_limit != 0 && cycles >= cycle_limit);
        $display("timeout: the pipeline never finished the program within %0d cycles",
                 cycle_limit);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== bench/program_testdata.txt ====
// columns in hex: instruction word, expected write flag, destination, data, test number
// entry k is fetched from address 100 + 4*k
20010005 1 01 00000005 2 // addi $1,$0,5
2002FFFD 1 02 FFFFFFFD 2 // addi $2,$0,-3
20031236 1 03 00001236 2 // addi $3,$0,0x1236
20048000 1 04 FFFF8000 2 // addi $4,$0,-32768
20250064 1 05 00000069 2 // addi $5,$1,100
00223020 1 06 00000002 3 // add $6,$1,$2
00233822 1 07 FFFFEDCF 3 // sub $7,$1,$3
00624024 1 08 00001234 3 // and $8,$3,$2
00234825 1 09 00001237 3 // or $9,$1,$3
00255027 1 0A FFFFFF92 3 // nor $10,$1,$5
0041582A 1 0B 00000001 3 // slt $11,$2,$1
0022602A 1 0C 00000000 3 // slt $12,$1,$2
20200007 1 00 0000000C 4 // addi $0,$1,7
00016822 1 0D FFFFFFFB 4 // sub $13,$0,$1
00000000 0 00 00000000 4
00000000 0 00 00000000 4
00077020 1 0E FFFFEDCF 4 // add $14,$0,$7
AC290023 0 00 00000000 5 // sw $9,35($1)
8CCF0026 1 0F 00001237 5 // lw $15,38($6)
00000000 0 00 00000000 6
10220003 0 00 00000000 6 // beq opcode, unsupported
00221804 0 00 00000000 6 // funct 4, unsupported
00000000 0 00 00000000 6

// ==== files.f ====
common/isa_pkg.sv
common/pipeline_pkg.sv
fetch/fetch_stage.sv
decode/register_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
memory/memory_stage.sv
design/processor.sv
bench/processor_tb.sv
